//--- f2c_cfg.svh
`ifndef F2C_CFG_SVH
`define F2C_CFG_SVH

// width of one packet flit in bits
`define F2C_FLIT_W 512

// entries in the packet and descriptor FIFOs
`define F2C_FIFO_DEPTH 64

// width of the CPU ring buffer head and tail pointers
`define F2C_RB_AWIDTH 12

// width of a queue table index
`define F2C_QID_W 6

// largest PCIe write burst in flits
`define F2C_MAX_BURST 8

`endif

//--- f2c_flit_pkg.sv
`include "f2c_cfg.svh"

package f2c_flit_pkg;

    // one beat of packet data coming from the FPGA side
    typedef struct packed {
        logic [`F2C_FLIT_W-1:0] data;
        logic                   sop;
        logic                   eop;
    } flit_t;

    // per packet descriptor, size is counted in flits
    typedef struct packed {
        logic [`F2C_QID_W-1:0] pkt_queue_id;
        logic [`F2C_QID_W-1:0] dsc_queue_id;
        logic [11:0]           size;
    } pkt_desc_t;

    // DMA controller states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        START_BURST,
        COMPLETE_BURST,
        WRITE_DESC,
        WRITE_TAIL
    } dma_state_t;

endpackage

//--- f2c_ring_pkg.sv
`include "f2c_cfg.svh"

package f2c_ring_pkg;

    // head or tail index into a CPU ring
    typedef logic [`F2C_RB_AWIDTH-1:0] rb_ptr_t;

    // ring size in flits
    typedef logic [30:0] rb_size_t;

    // index into the queue table
    typedef logic [`F2C_QID_W-1:0] qid_t;

    // host memory byte address
    typedef logic [63:0] host_addr_t;

    // PCIe burst count
    typedef logic [3:0] burst_len_t;

    // completion descriptor, one flit, signal sits in bit 0
    typedef struct packed {
        logic [`F2C_FLIT_W-66-`F2C_QID_W:0] pad;
        qid_t                               queue_id;
        logic [63:0]                        tail;
        logic                               signal;
    } pcie_pkt_desc_t;

endpackage

//--- f2c_fifo.sv
`timescale 1ns/1ps

module f2c_fifo
    import f2c_ring_pkg::*;
#(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready,
    output rb_ptr_t          occup
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             push;
    logic             pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_ready && out_valid;
    assign in_ready  = count != (AW+1)'(DEPTH);
    assign out_valid = count != '0;
    // show-ahead, the head entry is always on out_data
    assign out_data  = mem[rd_ptr];
    assign occup     = rb_ptr_t'(count);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the source must respect in_ready
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) in_valid |-> in_ready)
        else $error("f2c_fifo: write while full");

    // the consumer may only pop a valid head
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) out_ready |-> out_valid)
        else $error("f2c_fifo: pop while empty");

endmodule

//--- f2c_ring_space.sv
`timescale 1ns/1ps
`include "f2c_cfg.svh"

module f2c_ring_space
    import f2c_ring_pkg::*;
(
    input  rb_ptr_t     pkt_head,
    input  rb_ptr_t     pkt_tail,
    input  rb_ptr_t     dsc_head,
    input  rb_ptr_t     dsc_tail,
    input  rb_size_t    pkt_rb_size,
    input  rb_size_t    dsc_rb_size,
    input  logic [11:0] missing_flits,
    output logic        pkt_fits,
    output logic        dsc_fits,
    output burst_len_t  burst_len
);

    localparam int AW = `F2C_RB_AWIDTH;

    rb_ptr_t     pkt_free;
    rb_ptr_t     dsc_free;
    logic [AW:0] to_end;
    logic [AW:0] len;

    // one slot of each ring stays empty so full and empty differ
    always_comb begin
        if (pkt_tail >= pkt_head) begin
            pkt_free = pkt_rb_size[AW-1:0] - pkt_tail + pkt_head - 1'b1;
        end else begin
            pkt_free = pkt_head - pkt_tail - 1'b1;
        end
        if (dsc_tail >= dsc_head) begin
            dsc_free = dsc_rb_size[AW-1:0] - dsc_tail + dsc_head - 1'b1;
        end else begin
            dsc_free = dsc_head - dsc_tail - 1'b1;
        end
    end

    assign pkt_fits = pkt_free >= missing_flits;
    assign dsc_fits = dsc_free != '0;

    // slots left before the packet ring wraps
    assign to_end = pkt_rb_size[AW:0] - {1'b0, pkt_tail};

    always_comb begin
        len = (AW+1)'(missing_flits);
        if (len > (AW+1)'(`F2C_MAX_BURST)) begin
            len = (AW+1)'(`F2C_MAX_BURST);
        end
        // a burst never runs past the end of the ring
        if (len > to_end) begin
            len = to_end;
        end
    end

    assign burst_len = burst_len_t'(len);

endmodule

//--- f2c_dma_ctrl.sv
`timescale 1ns/1ps

module f2c_dma_ctrl
    import f2c_flit_pkg::*;
    import f2c_ring_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  flit_t        pkt_data,
    input  logic         pkt_valid,
    output logic         pkt_pop,
    input  pkt_desc_t    desc_data,
    input  logic         desc_valid,
    output logic         desc_pop,
    input  rb_ptr_t      in_pkt_head,
    input  rb_ptr_t      in_pkt_tail,
    input  rb_ptr_t      in_dsc_head,
    input  rb_ptr_t      in_dsc_tail,
    input  host_addr_t   in_pkt_buf_addr,
    input  host_addr_t   in_dsc_buf_addr,
    input  logic         in_pkt_q_needs_dsc,
    input  logic         queue_ready,
    output qid_t         rd_pkt_queue,
    output qid_t         rd_dsc_queue,
    output qid_t         wr_pkt_queue,
    output qid_t         wr_dsc_queue,
    output logic         queue_rd_en,
    output logic         tail_wr_en,
    output rb_ptr_t      out_pkt_tail,
    output rb_ptr_t      out_dsc_tail,
    input  rb_size_t     pkt_rb_size,
    input  rb_size_t     dsc_rb_size,
    input  logic         pcie_bas_waitrequest,
    output host_addr_t   pcie_bas_address,
    output logic [63:0]  pcie_bas_byteenable,
    output logic         pcie_bas_write,
    output logic [511:0] pcie_bas_writedata,
    output burst_len_t   pcie_bas_burstcount
);

    dma_state_t     state;
    pkt_desc_t      cur_desc;
    rb_ptr_t        cur_pkt_head;
    rb_ptr_t        cur_pkt_tail;
    rb_ptr_t        cur_dsc_head;
    rb_ptr_t        cur_dsc_tail;
    host_addr_t     cur_pkt_buf_addr;
    host_addr_t     cur_dsc_buf_addr;
    logic           cur_needs_dsc;
    logic           refetch;
    logic [11:0]    missing_flits;
    burst_len_t     burst_left;
    logic           pkt_fits;
    logic           dsc_fits;
    burst_len_t     burst_len;
    logic           pcie_free;
    logic           start_ok;
    logic           cont_ok;
    pcie_pkt_desc_t cpl_desc;

    function automatic rb_ptr_t next_ptr(rb_ptr_t ptr, rb_size_t size);
        rb_size_t nxt;
        nxt = rb_size_t'(ptr) + 31'd1;
        return (nxt >= size) ? '0 : rb_ptr_t'(nxt);
    endfunction

    // every ring slot is one 64-byte flit
    function automatic host_addr_t slot_addr(host_addr_t base, rb_ptr_t ptr);
        return base + (host_addr_t'(ptr) << 6);
    endfunction

    f2c_ring_space space (
        .pkt_head      (cur_pkt_head),
        .pkt_tail      (cur_pkt_tail),
        .dsc_head      (cur_dsc_head),
        .dsc_tail      (cur_dsc_tail),
        .pkt_rb_size   (pkt_rb_size),
        .dsc_rb_size   (dsc_rb_size),
        .missing_flits (missing_flits),
        .pkt_fits      (pkt_fits),
        .dsc_fits      (dsc_fits),
        .burst_len     (burst_len)
    );

    // the output register can take a new beat once the last one is accepted
    assign pcie_free = !pcie_bas_write || !pcie_bas_waitrequest;
    assign start_ok  = (state == START_BURST) && pcie_free && pkt_valid && pkt_fits && dsc_fits;
    assign cont_ok   = (state == COMPLETE_BURST) && pcie_free && pkt_valid;
    assign pkt_pop   = start_ok || cont_ok;
    assign desc_pop  = (state == IDLE) && desc_valid;

    assign pcie_bas_byteenable = '1;

    always_comb begin
        cpl_desc          = '0;
        cpl_desc.signal   = 1'b1;
        cpl_desc.tail     = 64'(cur_pkt_tail);
        cpl_desc.queue_id = cur_desc.pkt_queue_id;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= IDLE;
            pcie_bas_write <= 1'b0;
            queue_rd_en    <= 1'b0;
            tail_wr_en     <= 1'b0;
            refetch        <= 1'b0;
        end else begin
            queue_rd_en <= 1'b0;
            tail_wr_en  <= 1'b0;
            if (pcie_free) begin
                pcie_bas_write <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (desc_valid) begin
                        cur_desc     <= desc_data;
                        rd_pkt_queue <= desc_data.pkt_queue_id;
                        rd_dsc_queue <= desc_data.dsc_queue_id;
                        queue_rd_en  <= 1'b1;
                        refetch      <= 1'b0;
                        state        <= FETCH;
                    end
                end
                FETCH: begin
                    if (queue_ready) begin
                        cur_pkt_head     <= in_pkt_head;
                        cur_dsc_head     <= in_dsc_head;
                        cur_pkt_buf_addr <= in_pkt_buf_addr;
                        cur_dsc_buf_addr <= in_dsc_buf_addr;
                        cur_needs_dsc    <= in_pkt_q_needs_dsc;
                        // on a retry our own tails are newer than the table's
                        if (!refetch) begin
                            cur_pkt_tail  <= in_pkt_tail;
                            cur_dsc_tail  <= in_dsc_tail;
                            missing_flits <= cur_desc.size;
                        end
                        state <= START_BURST;
                    end
                end
                START_BURST: begin
                    if (start_ok) begin
                        pcie_bas_address    <= slot_addr(cur_pkt_buf_addr, cur_pkt_tail);
                        pcie_bas_writedata  <= pkt_data.data;
                        pcie_bas_burstcount <= burst_len;
                        pcie_bas_write      <= 1'b1;
                        cur_pkt_tail        <= next_ptr(cur_pkt_tail, pkt_rb_size);
                        missing_flits       <= missing_flits - 1'b1;
                        burst_left          <= burst_len - 1'b1;
                        if (missing_flits == 12'd1) begin
                            state <= WRITE_DESC;
                        end else if (burst_len != 4'd1) begin
                            state <= COMPLETE_BURST;
                        end
                    end else if (!pkt_fits || !dsc_fits) begin
                        // no room yet, read fresh heads
                        rd_pkt_queue <= cur_desc.pkt_queue_id;
                        rd_dsc_queue <= cur_desc.dsc_queue_id;
                        queue_rd_en  <= 1'b1;
                        refetch      <= 1'b1;
                        state        <= FETCH;
                    end
                end
                COMPLETE_BURST: begin
                    // address and burstcount hold from the first beat
                    if (cont_ok) begin
                        pcie_bas_writedata <= pkt_data.data;
                        pcie_bas_write     <= 1'b1;
                        cur_pkt_tail       <= next_ptr(cur_pkt_tail, pkt_rb_size);
                        missing_flits      <= missing_flits - 1'b1;
                        burst_left         <= burst_left - 1'b1;
                        if (burst_left == 4'd1) begin
                            state <= (missing_flits == 12'd1) ? WRITE_DESC : START_BURST;
                        end
                    end
                end
                WRITE_DESC: begin
                    if (pcie_free) begin
                        if (cur_needs_dsc) begin
                            pcie_bas_address    <= slot_addr(cur_dsc_buf_addr, cur_dsc_tail);
                            pcie_bas_writedata  <= cpl_desc;
                            pcie_bas_burstcount <= 4'd1;
                            pcie_bas_write      <= 1'b1;
                            cur_dsc_tail        <= next_ptr(cur_dsc_tail, dsc_rb_size);
                        end
                        state <= WRITE_TAIL;
                    end
                end
                WRITE_TAIL: begin
                    out_pkt_tail <= cur_pkt_tail;
                    out_dsc_tail <= cur_dsc_tail;
                    wr_pkt_queue <= cur_desc.pkt_queue_id;
                    wr_dsc_queue <= cur_desc.dsc_queue_id;
                    tail_wr_en   <= 1'b1;
                    state        <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // packet boundaries in the flit FIFO must agree with the descriptor sizes
    a_first_sop: assert property (@(posedge clk) disable iff (rst)
        start_ok && (missing_flits == cur_desc.size) |-> pkt_data.sop)
        else $error("f2c_dma_ctrl: first flit without sop");

    a_last_eop: assert property (@(posedge clk) disable iff (rst)
        pkt_pop && (missing_flits == 12'd1) |-> pkt_data.eop)
        else $error("f2c_dma_ctrl: last flit without eop");

endmodule

//--- fpga2cpu_pcie.sv
`timescale 1ns/1ps
`include "f2c_cfg.svh"

module fpga2cpu_pcie
    import f2c_flit_pkg::*;
    import f2c_ring_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // packet FIFO ingress
    input  flit_t        pkt_buf_wr_data,
    input  logic         pkt_buf_wr_en,
    output logic         pkt_buf_in_ready,
    output rb_ptr_t      pkt_buf_occup,
    // descriptor FIFO ingress
    input  pkt_desc_t    desc_buf_wr_data,
    input  logic         desc_buf_wr_en,
    output logic         desc_buf_in_ready,
    output rb_ptr_t      desc_buf_occup,
    // queue table
    input  rb_ptr_t      in_pkt_head,
    input  rb_ptr_t      in_pkt_tail,
    input  rb_ptr_t      in_dsc_head,
    input  rb_ptr_t      in_dsc_tail,
    input  host_addr_t   in_pkt_buf_addr,
    input  host_addr_t   in_dsc_buf_addr,
    input  logic         in_pkt_q_needs_dsc,
    input  logic         queue_ready,
    output qid_t         rd_pkt_queue,
    output qid_t         rd_dsc_queue,
    output qid_t         wr_pkt_queue,
    output qid_t         wr_dsc_queue,
    output logic         queue_rd_en,
    output logic         tail_wr_en,
    output rb_ptr_t      out_pkt_tail,
    output rb_ptr_t      out_dsc_tail,
    input  rb_size_t     pkt_rb_size,
    input  rb_size_t     dsc_rb_size,
    // PCIe write port
    input  logic         pcie_bas_waitrequest,
    output host_addr_t   pcie_bas_address,
    output logic [63:0]  pcie_bas_byteenable,
    output logic         pcie_bas_write,
    output logic [511:0] pcie_bas_writedata,
    output burst_len_t   pcie_bas_burstcount
);

    flit_t     pkt_rd_data;
    logic      pkt_out_valid;
    logic      pkt_pop;
    pkt_desc_t desc_rd_data;
    logic      desc_out_valid;
    logic      desc_pop;

    f2c_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (`F2C_FIFO_DEPTH)
    ) pkt_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pkt_buf_wr_data),
        .in_valid  (pkt_buf_wr_en),
        .in_ready  (pkt_buf_in_ready),
        .out_data  (pkt_rd_data),
        .out_valid (pkt_out_valid),
        .out_ready (pkt_pop),
        .occup     (pkt_buf_occup)
    );

    f2c_fifo #(
        .WIDTH ($bits(pkt_desc_t)),
        .DEPTH (`F2C_FIFO_DEPTH)
    ) desc_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (desc_buf_wr_data),
        .in_valid  (desc_buf_wr_en),
        .in_ready  (desc_buf_in_ready),
        .out_data  (desc_rd_data),
        .out_valid (desc_out_valid),
        .out_ready (desc_pop),
        .occup     (desc_buf_occup)
    );

    f2c_dma_ctrl ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .pkt_data             (pkt_rd_data),
        .pkt_valid            (pkt_out_valid),
        .pkt_pop              (pkt_pop),
        .desc_data            (desc_rd_data),
        .desc_valid           (desc_out_valid),
        .desc_pop             (desc_pop),
        .in_pkt_head          (in_pkt_head),
        .in_pkt_tail          (in_pkt_tail),
        .in_dsc_head          (in_dsc_head),
        .in_dsc_tail          (in_dsc_tail),
        .in_pkt_buf_addr      (in_pkt_buf_addr),
        .in_dsc_buf_addr      (in_dsc_buf_addr),
        .in_pkt_q_needs_dsc   (in_pkt_q_needs_dsc),
        .queue_ready          (queue_ready),
        .rd_pkt_queue         (rd_pkt_queue),
        .rd_dsc_queue         (rd_dsc_queue),
        .wr_pkt_queue         (wr_pkt_queue),
        .wr_dsc_queue         (wr_dsc_queue),
        .queue_rd_en          (queue_rd_en),
        .tail_wr_en           (tail_wr_en),
        .out_pkt_tail         (out_pkt_tail),
        .out_dsc_tail         (out_dsc_tail),
        .pkt_rb_size          (pkt_rb_size),
        .dsc_rb_size          (dsc_rb_size),
        .pcie_bas_waitrequest (pcie_bas_waitrequest),
        .pcie_bas_address     (pcie_bas_address),
        .pcie_bas_byteenable  (pcie_bas_byteenable),
        .pcie_bas_write       (pcie_bas_write),
        .pcie_bas_writedata   (pcie_bas_writedata),
        .pcie_bas_burstcount  (pcie_bas_burstcount)
    );

endmodule

//--- tb_fpga2cpu_pcie.sv
`timescale 1ns/1ps
`include "f2c_cfg.svh"

module tb_fpga2cpu_pcie
    import f2c_flit_pkg::*;
    import f2c_ring_pkg::*;
();

    logic         clk;
    logic         rst;
    flit_t        pkt_buf_wr_data;
    logic         pkt_buf_wr_en;
    logic         pkt_buf_in_ready;
    rb_ptr_t      pkt_buf_occup;
    pkt_desc_t    desc_buf_wr_data;
    logic         desc_buf_wr_en;
    logic         desc_buf_in_ready;
    rb_ptr_t      desc_buf_occup;
    rb_ptr_t      in_pkt_head;
    rb_ptr_t      in_pkt_tail;
    rb_ptr_t      in_dsc_head;
    rb_ptr_t      in_dsc_tail;
    host_addr_t   in_pkt_buf_addr;
    host_addr_t   in_dsc_buf_addr;
    logic         in_pkt_q_needs_dsc;
    logic         queue_ready;
    qid_t         rd_pkt_queue;
    qid_t         rd_dsc_queue;
    qid_t         wr_pkt_queue;
    qid_t         wr_dsc_queue;
    logic         queue_rd_en;
    logic         tail_wr_en;
    rb_ptr_t      out_pkt_tail;
    rb_ptr_t      out_dsc_tail;
    rb_size_t     pkt_rb_size;
    rb_size_t     dsc_rb_size;
    logic         pcie_bas_waitrequest;
    host_addr_t   pcie_bas_address;
    logic [63:0]  pcie_bas_byteenable;
    logic         pcie_bas_write;
    logic [511:0] pcie_bas_writedata;
    burst_len_t   pcie_bas_burstcount;

    // current stimulus line
    int pq;
    int dq;
    int size;
    int ph1;
    int pt;
    int dh1;
    int dt;
    int ph2;
    int dh2;
    int psz;
    int dsz;
    int needs;
    int stall;
    int reads;
    logic [31:0] rng;

    // accepted PCIe beats and tail writes, in arrival order
    host_addr_t   got_addr[$];
    logic [511:0] got_data[$];
    burst_len_t   got_bc[$];
    qid_t         tail_pq[$];
    qid_t         tail_dq[$];
    rb_ptr_t      tail_pt[$];
    rb_ptr_t      tail_dt[$];

    fpga2cpu_pcie dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic host_addr_t pkt_base(int q);
        return 64'h0000_0010_0000_0000 + (host_addr_t'(q) << 20);
    endfunction

    function automatic host_addr_t dsc_base(int q);
        return 64'h0000_0020_0000_0000 + (host_addr_t'(q) << 20);
    endfunction

    // used slots run from head up to tail, one slot always stays empty
    function automatic int free_slots(int head, int tail, int rsize);
        int used;
        used = (tail - head + rsize) % rsize;
        return rsize - 1 - used;
    endfunction

    task automatic make_flit_data(output logic [511:0] d);
        for (int i = 0; i < 16; i++) begin
            rng = lcg_next(rng);
            d[i*32 +: 32] = rng;
        end
    endtask

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_value(string name, logic [511:0] got, logic [511:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        stop_run();
    endtask

    task automatic report_problem(string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic check_qid(string name, qid_t got, qid_t exp);
        if (got !== exp) begin
            report_value(name, got, exp);
        end
    endtask

    task automatic check_occup(string name, rb_ptr_t got, rb_ptr_t exp);
        if (got !== exp) begin
            report_value(name, got, exp);
        end
    endtask

    // compares against the oldest accepted beat and removes it
    task automatic check_beat(host_addr_t addr, logic [511:0] data, burst_len_t bc);
        host_addr_t   ga;
        logic [511:0] gd;
        burst_len_t   gb;
        ga = got_addr.pop_front();
        gd = got_data.pop_front();
        gb = got_bc.pop_front();
        if (ga !== addr) begin
            report_value("pcie_bas_address", ga, addr);
        end
        if (gd !== data) begin
            report_value("pcie_bas_writedata", gd, data);
        end
        if (gb !== bc) begin
            report_value("pcie_bas_burstcount", gb, bc);
        end
    endtask

    task automatic check_desc(pcie_pkt_desc_t exp);
        pcie_pkt_desc_t got;
        got = pcie_pkt_desc_t'(got_data[0]);
        if (got.signal !== exp.signal) begin
            report_value("desc.signal", got.signal, exp.signal);
        end
        if (got.tail !== exp.tail) begin
            report_value("desc.tail", got.tail, exp.tail);
        end
        if (got.queue_id !== exp.queue_id) begin
            report_value("desc.queue_id", got.queue_id, exp.queue_id);
        end
        if (got.pad !== exp.pad) begin
            report_value("desc.pad", got.pad, exp.pad);
        end
    endtask

    task automatic check_tail(string side, qid_t got_q, rb_ptr_t got_t, qid_t exp_q,
                              rb_ptr_t exp_t);
        check_qid({"wr_", side, "_queue"}, got_q, exp_q);
        if (got_t !== exp_t) begin
            report_value({"out_", side, "_tail"}, got_t, exp_t);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (pcie_bas_write && !pcie_bas_waitrequest) begin
                if (pcie_bas_byteenable !== {64{1'b1}}) begin
                    report_value("pcie_bas_byteenable", pcie_bas_byteenable, {64{1'b1}});
                end
                got_addr.push_back(pcie_bas_address);
                got_data.push_back(pcie_bas_writedata);
                got_bc.push_back(pcie_bas_burstcount);
            end
            if (tail_wr_en) begin
                tail_pq.push_back(wr_pkt_queue);
                tail_dq.push_back(wr_dsc_queue);
                tail_pt.push_back(out_pkt_tail);
                tail_dt.push_back(out_dsc_tail);
            end
        end
    end

    // queue table, answers each read after 1 to 4 cycles
    initial begin : queue_table
        int delay;
        forever begin
            @(posedge clk);
            if (!rst && queue_rd_en) begin
                check_qid("rd_pkt_queue", rd_pkt_queue, qid_t'(pq));
                check_qid("rd_dsc_queue", rd_dsc_queue, qid_t'(dq));
                reads++;
                rng = lcg_next(rng);
                delay = int'(rng[17:16]);
                repeat (delay) @(negedge clk);
                @(negedge clk);
                queue_ready        = 1'b1;
                in_pkt_head        = rb_ptr_t'((reads == 1) ? ph1 : ph2);
                in_dsc_head        = rb_ptr_t'((reads == 1) ? dh1 : dh2);
                // a re-read returns tails that the controller must ignore
                in_pkt_tail        = (reads == 1) ? rb_ptr_t'(pt) : ~rb_ptr_t'(pt);
                in_dsc_tail        = (reads == 1) ? rb_ptr_t'(dt) : ~rb_ptr_t'(dt);
                in_pkt_buf_addr    = pkt_base(pq);
                in_dsc_buf_addr    = dsc_base(dq);
                in_pkt_q_needs_dsc = (needs != 0);
                @(negedge clk);
                queue_ready = 1'b0;
            end
        end
    end

    // waitrequest is high for stall cycles, then low for one
    initial begin : waitrequest_pattern
        int phase;
        phase = 0;
        forever begin
            @(negedge clk);
            if (stall == 0) begin
                pcie_bas_waitrequest = 1'b0;
                phase = 0;
            end else begin
                pcie_bas_waitrequest = (phase != stall);
                phase = (phase == stall) ? 0 : phase + 1;
            end
        end
    end

    task automatic run_packet();
        logic [511:0]   d;
        logic [511:0]   flit_data[$];
        rb_ptr_t        tail;
        rb_ptr_t        exp_dsc_tail;
        host_addr_t     start;
        pcie_pkt_desc_t exp_desc;
        int             left;
        int             len;
        int             exp_reads;
        int             exp_beats;
        int             t;

        @(negedge clk);
        pkt_rb_size = rb_size_t'(psz);
        dsc_rb_size = rb_size_t'(dsz);
        reads = 0;
        exp_reads = (free_slots(ph1, pt, psz) < size || free_slots(dh1, dt, dsz) < 1) ? 2 : 1;
        for (int i = 0; i < size; i++) begin
            make_flit_data(d);
            flit_data.push_back(d);
        end

        // the previous packet has drained both FIFOs
        check_occup("pkt_buf_occup", pkt_buf_occup, '0);
        check_occup("desc_buf_occup", desc_buf_occup, '0);

        if (!desc_buf_in_ready) begin
            report_problem("descriptor FIFO full on write");
        end
        desc_buf_wr_data.pkt_queue_id = qid_t'(pq);
        desc_buf_wr_data.dsc_queue_id = qid_t'(dq);
        desc_buf_wr_data.size         = 12'(size);
        desc_buf_wr_en = 1'b1;
        @(negedge clk);
        desc_buf_wr_en = 1'b0;
        check_occup("desc_buf_occup", desc_buf_occup, rb_ptr_t'(1));
        for (int i = 0; i < size; i++) begin
            if (!pkt_buf_in_ready) begin
                report_problem("packet FIFO full on write");
            end
            pkt_buf_wr_data.data = flit_data[i];
            pkt_buf_wr_data.sop  = (i == 0);
            pkt_buf_wr_data.eop  = (i == size - 1);
            pkt_buf_wr_en = 1'b1;
            @(negedge clk);
            if (i == 0) begin
                // nothing is popped before the queue state comes back
                check_occup("pkt_buf_occup", pkt_buf_occup, rb_ptr_t'(1));
            end
        end
        pkt_buf_wr_en = 1'b0;

        t = 0;
        while (tail_pq.size() == 0) begin
            @(negedge clk);
            t++;
            if (t > 2000) begin
                report_problem("timeout waiting for the tail write");
            end
        end
        // the descriptor beat may still be stalled when the tails go out
        exp_beats = size + ((needs != 0) ? 1 : 0);
        t = 0;
        while (got_addr.size() < exp_beats || pcie_bas_write) begin
            @(negedge clk);
            t++;
            if (t > 500) begin
                report_problem("timeout waiting for the PCIe beats of a packet");
            end
        end
        if (got_addr.size() != exp_beats) begin
            report_problem($sformatf("%0d PCIe beats seen, %0d expected",
                                     got_addr.size(), exp_beats));
        end
        if (reads != exp_reads) begin
            report_problem($sformatf("%0d queue reads seen, %0d expected", reads, exp_reads));
        end
        if (tail_pq.size() != 1) begin
            report_problem("more than one tail write for a packet");
        end

        tail = rb_ptr_t'(pt);
        left = size;
        while (left > 0) begin
            len = left;
            if (len > `F2C_MAX_BURST) begin
                len = `F2C_MAX_BURST;
            end
            if (len > psz - int'(tail)) begin
                len = psz - int'(tail);
            end
            start = pkt_base(pq) + host_addr_t'(tail) * 64;
            for (int k = 0; k < len; k++) begin
                check_beat(start, flit_data[size - left + k], burst_len_t'(len));
                tail = (int'(tail) + 1 >= psz) ? '0 : tail + 1'b1;
            end
            left -= len;
        end

        exp_dsc_tail = rb_ptr_t'(dt);
        if (needs != 0) begin
            exp_desc          = '0;
            exp_desc.signal   = 1'b1;
            exp_desc.tail     = 64'(tail);
            exp_desc.queue_id = qid_t'(pq);
            check_desc(exp_desc);
            check_beat(dsc_base(dq) + host_addr_t'(dt) * 64, exp_desc, 4'd1);
            exp_dsc_tail = (dt + 1 >= dsz) ? '0 : rb_ptr_t'(dt + 1);
        end
        check_tail("pkt", tail_pq.pop_front(), tail_pt.pop_front(), qid_t'(pq), tail);
        check_tail("dsc", tail_dq.pop_front(), tail_dt.pop_front(), qid_t'(dq), exp_dsc_tail);
    endtask

    initial begin : main
        int    fd;
        int    n;
        int    packets;
        string line;

        rst                  = 1'b1;
        pkt_buf_wr_data      = '0;
        pkt_buf_wr_en        = 1'b0;
        desc_buf_wr_data     = '0;
        desc_buf_wr_en       = 1'b0;
        in_pkt_head          = '0;
        in_pkt_tail          = '0;
        in_dsc_head          = '0;
        in_dsc_tail          = '0;
        in_pkt_buf_addr      = '0;
        in_dsc_buf_addr      = '0;
        in_pkt_q_needs_dsc   = 1'b0;
        queue_ready          = 1'b0;
        pkt_rb_size          = 31'd64;
        dsc_rb_size          = 31'd32;
        pcie_bas_waitrequest = 1'b0;
        stall                = 0;
        rng                  = 32'hdd20;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        if (pcie_bas_write || queue_rd_en || tail_wr_en) begin
            report_problem("strobes not low after reset");
        end

        fd = $fopen("f2c_stim.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open f2c_stim.txt");
        end
        packets = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d", pq, dq, size,
                            ph1, pt, dh1, dt, ph2, dh2, psz, dsz, needs, stall);
                if (n == 13) begin
                    run_packet();
                    packets++;
                end
            end
        end
        $fclose(fd);
        if (packets == 0) begin
            report_problem("no packets found in f2c_stim.txt");
        end

        // nothing may follow the last packet
        repeat (20) @(negedge clk);
        if (got_addr.size() != 0 || tail_pq.size() != 0) begin
            report_problem("PCIe beat or tail write after the last packet");
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- f2c_stim.txt
# pkt_q dsc_q size pkt_head1 pkt_tail dsc_head1 dsc_tail pkt_head2 dsc_head2
# pkt_rb_size dsc_rb_size needs_dsc stall   (all decimal, one packet per line)
0 1 1 0 0 0 0 0 0 64 32 1 0
1 2 8 0 0 0 0 0 0 64 32 1 0
2 3 20 0 10 0 5 0 0 64 32 1 0
3 4 12 30 60 0 0 30 0 64 32 1 0
4 5 5 0 0 0 0 0 0 64 32 0 0
5 6 10 0 3 0 7 0 0 64 32 1 2
6 7 10 5 0 0 0 20 0 64 32 1 0
7 8 3 0 0 4 3 0 10 64 32 1 1
8 9 4 0 0 5 31 0 5 64 32 1 0
9 10 16 50 95 0 0 50 0 100 50 1 3
63 62 7 0 2 0 1 0 0 64 32 1 1
10 11 6 7 0 0 0 7 0 64 32 1 0
11 12 7 7 0 0 0 30 0 64 32 1 0
12 13 40 0 0 0 0 0 0 64 32 1 1
13 14 9 20 63 0 0 20 0 64 32 0 2
14 15 2 0 0 0 1 0 1 64 2 1 0
15 16 10 0 12 0 0 11 0 16 32 1 0
16 17 5 3 2 0 0 40 0 64 32 0 1

//--- project.f
+incdir+.
f2c_flit_pkg.sv
f2c_ring_pkg.sv
f2c_fifo.sv
f2c_ring_space.sv
f2c_dma_ctrl.sv
fpga2cpu_pcie.sv
tb_fpga2cpu_pcie.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fpga2cpu_pcie \
    -f project.f -o sim > build.log 2>&1 \
    && ./obj_dir/sim > sim.log 2>&1 \
    || cat build.log
cat sim.log 2>/dev/null
grep -q '^\*\*\* PASSED \*\*\*$' sim.log 2>/dev/null && exit 0 || exit 1
